// File: hba_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HBA bus widths, register map and register bank states.
// Imported by the bus-facing blocks of the TX peripheral.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package hba_bus_pkg;

    localparam int DBUS_WIDTH        = 8;
    localparam int PERIPH_ADDR_WIDTH = 4;   // Upper address field
    localparam int REG_ADDR_WIDTH    = 8;   // Lower address field
    localparam int ADDR_WIDTH        = PERIPH_ADDR_WIDTH + REG_ADDR_WIDTH;

    // Register indices relative to REG_OFFSET
    localparam int REG_CTRL   = 0;
    localparam int REG_DATA   = 1;
    localparam int REG_STATUS = 2;
    localparam int REG_COUNT  = 3;   // Cleared when read

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        WAIT
    } regbank_state_e;

endpackage

// File: tx_core_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control and status bit layout, commands and push FSM states
// used by the transmit core behind the register bank.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package tx_core_pkg;

    // Control register
    localparam int CTRL_SEND_BIT  = 0;
    localparam int CTRL_FLUSH_BIT = 1;

    // Status register, FIFO level sits in the low bits
    localparam int STATUS_FULL_BIT = 7;

    // Flush outranks send when both bits are set
    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_SEND,
        CMD_FLUSH
    } tx_cmd_e;

    typedef enum logic {
        PUSH_IDLE,
        PUSH_ACK   // Lets the control write-back settle
    } push_state_e;

endpackage

// File: hba_reg_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-register HBA bus slave. The bus reads and writes the registers,
// the core updates them through a masked write port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hba_reg_bank import hba_bus_pkg::*; #(
    parameter int PERIPH_ADDR = 2,
    parameter int REG_OFFSET  = 0
) (
    input  logic                  hba_clk,
    input  logic                  hba_reset,
    input  logic                  hba_rnw,      // 1 = read
    input  logic                  hba_select,
    input  logic [ADDR_WIDTH-1:0] hba_abus,
    input  logic [DBUS_WIDTH-1:0] hba_dbus,
    output logic [DBUS_WIDTH-1:0] hba_dbus_slave,
    output logic                  hba_xferack_slave,
    output logic [DBUS_WIDTH-1:0] slv_reg0,
    output logic [DBUS_WIDTH-1:0] slv_reg1,
    output logic [DBUS_WIDTH-1:0] slv_reg2,
    output logic [DBUS_WIDTH-1:0] slv_reg3,
    input  logic [DBUS_WIDTH-1:0] slv_reg0_in,
    input  logic [DBUS_WIDTH-1:0] slv_reg1_in,
    input  logic [DBUS_WIDTH-1:0] slv_reg2_in,
    input  logic [DBUS_WIDTH-1:0] slv_reg3_in,
    input  logic                  slv_wr_en,
    input  logic [3:0]            slv_wr_mask,      // One bit per register
    input  logic [3:0]            slv_autoclr_mask  // Clear on bus read
);

    logic [REG_ADDR_WIDTH-1:0]    reg_addr;
    logic [PERIPH_ADDR_WIDTH-1:0] periph_addr;
    logic [REG_ADDR_WIDTH-1:0]    reg_rel;
    logic [1:0]                   reg_sel;
    logic                         addr_decode_hit;
    logic                         sel_hit_q;
    logic                         addr_hit;
    logic                         addr_hit_clear;
    regbank_state_e               regbank_state;
    logic [DBUS_WIDTH-1:0]        regs    [4];
    logic [DBUS_WIDTH-1:0]        regs_in [4];

    assign reg_addr    = hba_abus[REG_ADDR_WIDTH-1:0];
    assign periph_addr = hba_abus[ADDR_WIDTH-1:REG_ADDR_WIDTH];
    assign reg_rel     = reg_addr - REG_ADDR_WIDTH'(REG_OFFSET);
    assign reg_sel     = reg_rel[1:0];   // Only meaningful on a hit

    assign addr_decode_hit = (periph_addr == PERIPH_ADDR_WIDTH'(PERIPH_ADDR)) &&
                             (reg_rel < REG_ADDR_WIDTH'(4)) &&
                             (reg_addr >= REG_ADDR_WIDTH'(REG_OFFSET));
    assign addr_hit_clear  = ~hba_select | hba_xferack_slave;

    assign regs_in[0] = slv_reg0_in;
    assign regs_in[1] = slv_reg1_in;
    assign regs_in[2] = slv_reg2_in;
    assign regs_in[3] = slv_reg3_in;

    assign slv_reg0 = regs[0];
    assign slv_reg1 = regs[1];
    assign slv_reg2 = regs[2];
    assign slv_reg3 = regs[3];

    // Sample select and decode, then qualify into addr_hit
    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            sel_hit_q <= 1'b0;
            addr_hit  <= 1'b0;
        end else begin
            sel_hit_q <= hba_select & addr_decode_hit & ~hba_xferack_slave;
            addr_hit  <= addr_hit_clear ? 1'b0 : sel_hit_q;
        end
    end

    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            regbank_state     <= IDLE;
            hba_xferack_slave <= 1'b0;
            hba_dbus_slave    <= '0;
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Core writes first so a bus access in the same cycle overrides
            if (slv_wr_en) begin
                for (int i = 0; i < 4; i++) begin
                    if (slv_wr_mask[i]) begin
                        regs[i] <= regs_in[i];
                    end
                end
            end

            case (regbank_state)
                IDLE: begin
                    hba_xferack_slave <= 1'b0;
                    hba_dbus_slave    <= '0;
                    if (addr_hit) begin
                        regbank_state <= hba_rnw ? READ : WRITE;
                    end
                end
                READ: begin
                    hba_xferack_slave <= 1'b1;
                    hba_dbus_slave    <= regs[reg_sel];
                    if (slv_autoclr_mask[reg_sel]) begin
                        regs[reg_sel] <= '0;
                    end
                    regbank_state <= WAIT;
                end
                WRITE: begin
                    hba_xferack_slave <= 1'b1;
                    regs[reg_sel]     <= hba_dbus;
                    regbank_state     <= WAIT;
                end
                default: begin   // WAIT, one dead cycle after the ack
                    hba_xferack_slave <= 1'b0;
                    hba_dbus_slave    <= '0;
                    regbank_state     <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: tx_push_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Turns control register commands into FIFO pushes and flushes, and
// writes status and the sent count back into the register bank.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tx_push_ctrl import hba_bus_pkg::*, tx_core_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                        hba_clk,
    input  logic                        hba_reset,
    input  logic [DBUS_WIDTH-1:0]       ctrl_reg,
    input  logic [DBUS_WIDTH-1:0]       data_reg,
    input  logic [DBUS_WIDTH-1:0]       count_reg,
    input  logic [$clog2(FIFO_DEPTH):0] fifo_level,
    input  logic                        fifo_full,
    input  logic                        pop_done,
    output logic                        slv_wr_en,
    output logic [3:0]                  slv_wr_mask,
    output logic [DBUS_WIDTH-1:0]       slv_reg0_in,
    output logic [DBUS_WIDTH-1:0]       slv_reg2_in,
    output logic [DBUS_WIDTH-1:0]       slv_reg3_in,
    output logic                        fifo_push,
    output logic [DBUS_WIDTH-1:0]       fifo_wdata,
    output logic                        fifo_flush
);

    tx_cmd_e     cmd;
    push_state_e push_state;

    always_comb begin
        if (ctrl_reg[CTRL_FLUSH_BIT]) begin
            cmd = CMD_FLUSH;
        end else if (ctrl_reg[CTRL_SEND_BIT]) begin
            cmd = CMD_SEND;
        end else begin
            cmd = CMD_NONE;
        end
    end

    // Send waits here while full, which is the only back-pressure
    assign fifo_push  = (push_state == PUSH_IDLE) && (cmd == CMD_SEND) && !fifo_full;
    assign fifo_flush = (push_state == PUSH_IDLE) && (cmd == CMD_FLUSH);
    assign fifo_wdata = data_reg;

    assign slv_wr_en   = 1'b1;   // Status is refreshed every cycle
    assign slv_reg3_in = count_reg + 1'b1;

    always_comb begin
        slv_reg0_in = ctrl_reg;
        if (fifo_flush) begin
            slv_reg0_in[CTRL_FLUSH_BIT] = 1'b0;
        end else begin
            slv_reg0_in[CTRL_SEND_BIT] = 1'b0;
        end

        slv_reg2_in = '0;
        slv_reg2_in[$clog2(FIFO_DEPTH):0] = fifo_level;
        slv_reg2_in[STATUS_FULL_BIT]      = fifo_full;

        slv_wr_mask             = 4'b0000;
        slv_wr_mask[REG_STATUS] = 1'b1;
        slv_wr_mask[REG_CTRL]   = fifo_push | fifo_flush;
        slv_wr_mask[REG_COUNT]  = pop_done;
    end

    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            push_state <= PUSH_IDLE;
        end else begin
            case (push_state)
                PUSH_IDLE: begin
                    if (fifo_push || fifo_flush) begin
                        push_state <= PUSH_ACK;
                    end
                end
                default: push_state <= PUSH_IDLE;
            endcase
        end
    end

endmodule

// File: byte_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous byte FIFO with registered read data, level and flush.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module byte_fifo #(
    parameter int FIFO_DEPTH = 8   // Power of two
) (
    input  logic                        hba_clk,
    input  logic                        hba_reset,
    input  logic                        push,
    input  logic [7:0]                  wdata,
    input  logic                        pop,
    input  logic                        flush,
    output logic [7:0]                  rdata,
    output logic [$clog2(FIFO_DEPTH):0] level,
    output logic                        full,
    output logic                        empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] LEVEL_MAX = FIFO_DEPTH[PTR_W:0];

    logic [7:0]       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign full    = (level == LEVEL_MAX);
    assign empty   = (level == '0);
    assign do_push = push && !full && !flush;
    assign do_pop  = pop && !empty;   // Head byte still leaves during a flush

    always_ff @(posedge hba_clk) begin
        if (hba_reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) begin
                level <= level + 1'b1;
            end else if (do_pop && !do_push) begin
                level <= level - 1'b1;
            end
        end
    end

    always_ff @(posedge hba_clk) begin
        if (do_push) mem[wr_ptr] <= wdata;
        if (do_pop)  rdata <= mem[rd_ptr];   // Valid the cycle after pop
    end

endmodule

// File: tx_pacer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Drains the byte FIFO at most once per PACE_CYCLES clocks and shows
// each byte on tx_data with a one-cycle strobe.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tx_pacer #(
    parameter int PACE_CYCLES = 4   // At least 2
) (
    input  logic       hba_clk,
    input  logic       hba_reset,
    input  logic [7:0] fifo_rdata,
    input  logic       fifo_empty,
    output logic       fifo_pop,
    output logic [7:0] tx_data,
    output logic       tx_strobe,
    output logic       pop_done
);

    localparam int GAP_W = $clog2(PACE_CYCLES);

    logic [GAP_W-1:0] gap_cnt;
    logic             strobe_q;

    assign fifo_pop  = !fifo_empty && (gap_cnt == '0);
    assign tx_data   = fifo_rdata;   // FIFO read register holds the byte
    assign tx_strobe = strobe_q;
    assign pop_done  = strobe_q;

    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            gap_cnt  <= '0;
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= fifo_pop;
            if (fifo_pop) begin
                gap_cnt <= GAP_W'(PACE_CYCLES - 1);   // Next pop PACE_CYCLES later
            end else if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - 1'b1;
            end
        end
    end

endmodule

// File: hba_tx_periph.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HBA transmit peripheral. Bus writes queue bytes that leave on the
// paced tx_data/tx_strobe port. Instantiate once per bus slot.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hba_tx_periph import hba_bus_pkg::*; #(
    parameter int PERIPH_ADDR = 2,
    parameter int REG_OFFSET  = 0,
    parameter int FIFO_DEPTH  = 8,
    parameter int PACE_CYCLES = 4
) (
    input  logic                  hba_clk,
    input  logic                  hba_reset,
    input  logic                  hba_select,
    input  logic                  hba_rnw,
    input  logic [ADDR_WIDTH-1:0] hba_abus,
    input  logic [DBUS_WIDTH-1:0] hba_dbus,
    output logic [DBUS_WIDTH-1:0] hba_dbus_slave,
    output logic                  hba_xferack_slave,
    output logic [7:0]            tx_data,
    output logic                  tx_strobe
);

    localparam logic [3:0] AUTOCLR_MASK = 4'(1 << REG_COUNT);   // Count clears on read

    logic [DBUS_WIDTH-1:0]        slv_reg0;
    logic [DBUS_WIDTH-1:0]        slv_reg1;
    logic [DBUS_WIDTH-1:0]        slv_reg3;
    logic [DBUS_WIDTH-1:0]        slv_reg0_in;
    logic [DBUS_WIDTH-1:0]        slv_reg2_in;
    logic [DBUS_WIDTH-1:0]        slv_reg3_in;
    logic                         slv_wr_en;
    logic [3:0]                   slv_wr_mask;
    logic                         fifo_push;
    logic [DBUS_WIDTH-1:0]        fifo_wdata;
    logic                         fifo_flush;
    logic                         fifo_pop;
    logic [7:0]                   fifo_rdata;
    logic [$clog2(FIFO_DEPTH):0]  fifo_level;
    logic                         fifo_full;
    logic                         fifo_empty;
    logic                         pop_done;

    hba_reg_bank #(
        .PERIPH_ADDR (PERIPH_ADDR),
        .REG_OFFSET  (REG_OFFSET)
    ) u_reg_bank (
        .hba_clk           (hba_clk),
        .hba_reset         (hba_reset),
        .hba_rnw           (hba_rnw),
        .hba_select        (hba_select),
        .hba_abus          (hba_abus),
        .hba_dbus          (hba_dbus),
        .hba_dbus_slave    (hba_dbus_slave),
        .hba_xferack_slave (hba_xferack_slave),
        .slv_reg0          (slv_reg0),
        .slv_reg1          (slv_reg1),
        .slv_reg2          (),           // STATUS is only read over the bus
        .slv_reg3          (slv_reg3),
        .slv_reg0_in       (slv_reg0_in),
        .slv_reg1_in       (slv_reg1),   // DATA is bus-written only
        .slv_reg2_in       (slv_reg2_in),
        .slv_reg3_in       (slv_reg3_in),
        .slv_wr_en         (slv_wr_en),
        .slv_wr_mask       (slv_wr_mask),
        .slv_autoclr_mask  (AUTOCLR_MASK)
    );

    tx_push_ctrl #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_push_ctrl (
        .hba_clk     (hba_clk),
        .hba_reset   (hba_reset),
        .ctrl_reg    (slv_reg0),
        .data_reg    (slv_reg1),
        .count_reg   (slv_reg3),
        .fifo_level  (fifo_level),
        .fifo_full   (fifo_full),
        .pop_done    (pop_done),
        .slv_wr_en   (slv_wr_en),
        .slv_wr_mask (slv_wr_mask),
        .slv_reg0_in (slv_reg0_in),
        .slv_reg2_in (slv_reg2_in),
        .slv_reg3_in (slv_reg3_in),
        .fifo_push   (fifo_push),
        .fifo_wdata  (fifo_wdata),
        .fifo_flush  (fifo_flush)
    );

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .hba_clk   (hba_clk),
        .hba_reset (hba_reset),
        .push      (fifo_push),
        .wdata     (fifo_wdata),
        .pop       (fifo_pop),
        .flush     (fifo_flush),
        .rdata     (fifo_rdata),
        .level     (fifo_level),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

    tx_pacer #(
        .PACE_CYCLES (PACE_CYCLES)
    ) u_pacer (
        .hba_clk    (hba_clk),
        .hba_reset  (hba_reset),
        .fifo_rdata (fifo_rdata),
        .fifo_empty (fifo_empty),
        .fifo_pop   (fifo_pop),
        .tx_data    (tx_data),
        .tx_strobe  (tx_strobe),
        .pop_done   (pop_done)
    );

endmodule

// File: hba_tx_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus and strobe protocol assertions, bound into the TX peripheral.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hba_tx_checker import hba_bus_pkg::*; #(
    parameter int PACE_CYCLES = 4
) (
    input logic                  hba_clk,
    input logic                  hba_reset,
    input logic                  hba_xferack_slave,
    input logic [DBUS_WIDTH-1:0] hba_dbus_slave,
    input logic                  tx_strobe
);

    int since_strobe;   // Cycles since the last strobe, saturating

    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            since_strobe <= PACE_CYCLES;
        end else if (tx_strobe) begin
            since_strobe <= 1;
        end else if (since_strobe < PACE_CYCLES) begin
            since_strobe <= since_strobe + 1;
        end
    end

    ack_one_cycle: assert property (@(posedge hba_clk) disable iff (hba_reset)
        hba_xferack_slave |=> !hba_xferack_slave)
        else $error("xferack held for more than one cycle");

    dbus_idle_zero: assert property (@(posedge hba_clk) disable iff (hba_reset)
        !hba_xferack_slave |-> (hba_dbus_slave == '0))
        else $error("dbus_slave not zero outside the ack cycle");

    strobe_spacing: assert property (@(posedge hba_clk) disable iff (hba_reset)
        tx_strobe |-> (since_strobe >= PACE_CYCLES))
        else $error("tx_strobe pulses closer than PACE_CYCLES");

endmodule

bind hba_tx_periph hba_tx_checker #(
    .PACE_CYCLES (PACE_CYCLES)
) u_checker (
    .hba_clk           (hba_clk),
    .hba_reset         (hba_reset),
    .hba_xferack_slave (hba_xferack_slave),
    .hba_dbus_slave    (hba_dbus_slave),
    .tx_strobe         (tx_strobe)
);

// File: tb_hba_tx_periph.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the HBA transmit peripheral. Acts as bus master, keeps
// a model of the queued bytes and checks every tx_strobe against it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_hba_tx_periph import hba_bus_pkg::*, tx_core_pkg::*; ();

    localparam int PERIPH      = 2;
    localparam int FIFO_DEPTH  = 8;
    localparam int PACE        = 256;   // Slow drain so bus writes can fill the FIFO
    localparam int ACK_TIMEOUT = 20;
    localparam int POLL_LIMIT  = PACE;
    localparam int DRAIN_LIMIT = PACE * (FIFO_DEPTH + 4);

    logic                  hba_clk;
    logic                  hba_reset;
    logic                  hba_select;
    logic                  hba_rnw;
    logic [ADDR_WIDTH-1:0] hba_abus;
    logic [DBUS_WIDTH-1:0] hba_dbus;
    logic [DBUS_WIDTH-1:0] hba_dbus_slave;
    logic                  hba_xferack_slave;
    logic [7:0]            tx_data;
    logic                  tx_strobe;

    logic [7:0] exp_q [$];   // Bytes still owed on tx_data
    logic [7:0] exp_byte;
    int         sent_cnt;    // Bytes handed to the model since reset
    integer     seed;

    hba_tx_periph #(
        .PERIPH_ADDR (PERIPH),
        .REG_OFFSET  (0),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PACE_CYCLES (PACE)
    ) dut0 (
        .hba_clk           (hba_clk),
        .hba_reset         (hba_reset),
        .hba_select        (hba_select),
        .hba_rnw           (hba_rnw),
        .hba_abus          (hba_abus),
        .hba_dbus          (hba_dbus),
        .hba_dbus_slave    (hba_dbus_slave),
        .hba_xferack_slave (hba_xferack_slave),
        .tx_data           (tx_data),
        .tx_strobe         (tx_strobe)
    );

    always #10 hba_clk = ~hba_clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_bus(input string name, input logic [DBUS_WIDTH-1:0] got,
                             input logic [DBUS_WIDTH-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH %s: got 0x%02h, expected 0x%02h",
                                    name, got, exp));
        end
    endtask

    task automatic check_tx(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH tx_data: got 0x%02h, expected 0x%02h",
                                    got, exp));
        end
    endtask

    // Reference model: status byte for a FIFO level, count since last read
    function automatic logic [DBUS_WIDTH-1:0] expected_status(input int level);
        logic [DBUS_WIDTH-1:0] s;
        s = DBUS_WIDTH'(level);                         // Level in the low bits
        s[STATUS_FULL_BIT] = (level == FIFO_DEPTH);
        return s;
    endfunction

    function automatic logic [DBUS_WIDTH-1:0] expected_count(input int total, input int base);
        return DBUS_WIDTH'(total - base);
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] reg_addr(input int periph, input int idx);
        return {PERIPH_ADDR_WIDTH'(periph), REG_ADDR_WIDTH'(idx)};
    endfunction

    // One HBA transfer, select held until ack or timeout
    task automatic bus_xfer(input logic rnw, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DBUS_WIDTH-1:0] wdata,
                            output logic [DBUS_WIDTH-1:0] rdata, output logic acked);
        int t;
        acked = 1'b0;
        rdata = '0;
        t = 0;
        @(posedge hba_clk);
        hba_select <= 1'b1;
        hba_rnw    <= rnw;
        hba_abus   <= addr;
        hba_dbus   <= wdata;
        while (!acked && t < ACK_TIMEOUT) begin
            @(posedge hba_clk);
            if (hba_xferack_slave) begin
                acked = 1'b1;
                rdata = hba_dbus_slave;   // Valid only in the ack cycle
            end
            t++;
        end
        hba_select <= 1'b0;
    endtask

    task automatic bus_write(input int idx, input logic [DBUS_WIDTH-1:0] data);
        logic [DBUS_WIDTH-1:0] unused;
        logic                  acked;
        bus_xfer(1'b0, reg_addr(PERIPH, idx), data, unused, acked);
        if (!acked) stop_on_error($sformatf("No ack for bus write to register %0d", idx));
    endtask

    task automatic bus_read(input int idx, output logic [DBUS_WIDTH-1:0] data);
        logic acked;
        bus_xfer(1'b1, reg_addr(PERIPH, idx), '0, data, acked);
        if (!acked) stop_on_error($sformatf("No ack for bus read of register %0d", idx));
    endtask

    // DATA then send bit, then poll CTRL until the byte is taken
    task automatic send_byte(input logic [7:0] b, output logic saw_full);
        logic [DBUS_WIDTH-1:0] ctrl;
        logic [DBUS_WIDTH-1:0] status;
        int                    polls;
        saw_full = 1'b0;
        polls = 0;
        bus_write(REG_DATA, b);
        bus_write(REG_CTRL, DBUS_WIDTH'(1 << CTRL_SEND_BIT));
        exp_q.push_back(b);
        sent_cnt++;
        do begin
            bus_read(REG_CTRL, ctrl);
            if (ctrl[CTRL_SEND_BIT] && !saw_full) begin
                saw_full = 1'b1;   // Held send bit means the FIFO is full
                bus_read(REG_STATUS, status);
                check_bus("hba_dbus_slave (STATUS)", status, expected_status(FIFO_DEPTH));
            end
            polls++;
        end while (ctrl[CTRL_SEND_BIT] && polls < POLL_LIMIT);
        if (ctrl[CTRL_SEND_BIT]) stop_on_error("Send bit was never cleared by the controller");
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (exp_q.size() != 0) begin
            @(posedge hba_clk);
            t++;
            if (t > DRAIN_LIMIT) stop_on_error("Timed out waiting for queued bytes on tx_data");
        end
    endtask

    always @(posedge hba_clk) begin
        if (!hba_reset && tx_strobe) begin
            if (exp_q.size() == 0) begin
                stop_on_error("tx_strobe seen with no byte expected");
            end else begin
                exp_byte = exp_q.pop_front();
                check_tx(tx_data, exp_byte);
            end
        end
    end

    initial begin
        logic [DBUS_WIDTH-1:0] rd;
        logic [DBUS_WIDTH-1:0] wd;
        logic                  acked;
        logic                  hit;
        logic                  full_seen;
        int                    count_base;
        hba_clk    = 1'b0;
        seed       = 32'ha590;
        sent_cnt   = 0;
        count_base = 0;
        full_seen  = 1'b0;
        hba_reset  <= 1'b1;
        hba_select <= 1'b0;
        hba_rnw    <= 1'b0;
        hba_abus   <= '0;
        hba_dbus   <= '0;
        repeat (8) @(posedge hba_clk);
        hba_reset <= 1'b0;

        repeat (4) begin
            wd = DBUS_WIDTH'($random(seed));
            bus_write(REG_DATA, wd);
            bus_read(REG_DATA, rd);
            check_bus("hba_dbus_slave (DATA)", rd, wd);
        end
        bus_xfer(1'b1, reg_addr(PERIPH, 4), '0, rd, acked);   // Past the four registers
        if (acked) stop_on_error("Unmapped register address was acknowledged");
        bus_xfer(1'b1, reg_addr(PERIPH + 1, REG_CTRL), '0, rd, acked);
        if (acked) stop_on_error("Address of another peripheral was acknowledged");

        repeat (5) send_byte(8'($random(seed)), hit);
        wait_drained();

        for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
            send_byte(8'($random(seed)), hit);
            full_seen = full_seen | hit;
        end
        if (!full_seen) stop_on_error("FIFO never reported full during the overfill");
        wait_drained();

        bus_read(REG_COUNT, rd);
        check_bus("hba_dbus_slave (COUNT)", rd, expected_count(sent_cnt, count_base));
        count_base = sent_cnt;
        repeat (3) send_byte(8'($random(seed)), hit);
        wait_drained();
        bus_read(REG_COUNT, rd);
        check_bus("hba_dbus_slave (COUNT)", rd, expected_count(sent_cnt, count_base));
        count_base = sent_cnt;
        bus_read(REG_COUNT, rd);   // Cleared by the read before
        check_bus("hba_dbus_slave (COUNT)", rd, expected_count(sent_cnt, count_base));

        repeat (4) send_byte(8'($random(seed)), hit);
        bus_write(REG_CTRL, DBUS_WIDTH'(1 << CTRL_FLUSH_BIT));
        repeat (2) @(posedge hba_clk);   // Lets a pop from before the flush reach tx_strobe
        if (exp_q.size() == 0) stop_on_error("No bytes were queued when the flush was issued");
        exp_q.delete();
        repeat (2 * PACE) @(posedge hba_clk);
        bus_read(REG_STATUS, rd);
        check_bus("hba_dbus_slave (STATUS)", rd, expected_status(0));
        bus_read(REG_CTRL, rd);
        check_bus("hba_dbus_slave (CTRL)", rd, 8'h00);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: build.f
hba_bus_pkg.sv
tx_core_pkg.sv
hba_reg_bank.sv
tx_push_ctrl.sv
byte_fifo.sv
tx_pacer.sv
hba_tx_periph.sv
hba_tx_checker.sv
tb_hba_tx_periph.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the TX peripheral testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_hba_tx_periph -f build.f -o sim_tx
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tx
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
